//--- include/bus_config.svh
////////////////////
// Bus configuration
// Widths of the core data port, the timer block window
// and the register offsets inside that window
////////////////////
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

// Core data port widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// Timer block window of 64 KB
`define CLINT_BASE 32'h0200_0000
`define CLINT_SIZE 32'h0001_0000

// Register offsets inside the window
`define CLINT_MSIP_OFS        16'h0000
`define CLINT_MTIMECMP_LO_OFS 16'h0008
`define CLINT_MTIMECMP_HI_OFS 16'h000C

`endif

//--- source/bus_pkg.sv
////////////////////
// Bus types
// Core request and response, AXI4-Lite channels,
// interrupt bundle and bridge FSM states
////////////////////
`include "bus_config.svh"

package bus_pkg;

    typedef logic [`BUS_ADDR_W-1:0]   addr_t;
    typedef logic [`BUS_DATA_W-1:0]   data_t;
    typedef logic [`BUS_DATA_W/8-1:0] strb_t;
    typedef logic [1:0]               axi_resp_t;
    typedef logic [63:0]              mtime_t;

    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    ////////////////////
    // Core side
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
        logic  write;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  error;
    } mem_rsp_t;

    ////////////////////
    // AXI4-Lite master side
    typedef struct packed {
        logic  arvalid;
        addr_t araddr;
        logic  rready;
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        strb_t wstrb;
        logic  bready;
    } axi_m2s_t;

    typedef struct packed {
        logic      arready;
        logic      rvalid;
        data_t     rdata;
        axi_resp_t rresp;
        logic      awready;
        logic      wready;
        logic      bvalid;
        axi_resp_t bresp;
    } axi_s2m_t;

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } interrupt_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP
    } bridge_state_t;

endpackage

//--- source/req_router.sv
////////////////////
// Request router
// Sends each core request to the timer block or the AXI bridge,
// one transaction in flight, responses back in order
////////////////////
`timescale 1ns/1ps
`include "bus_config.svh"

module req_router (
    input  logic               clk,
    input  logic               rst_n,
    // Core side
    input  logic               req_valid,
    output logic               req_ready,
    input  bus_pkg::mem_req_t  req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output bus_pkg::mem_rsp_t  rsp,
    // AXI bridge side
    output logic               axi_req_valid,
    input  logic               axi_req_ready,
    input  logic               axi_rsp_valid,
    output logic               axi_rsp_ready,
    input  bus_pkg::mem_rsp_t  axi_rsp,
    // Timer block side
    output logic               clint_req_valid,
    input  logic               clint_req_ready,
    input  logic               clint_rsp_valid,
    output logic               clint_rsp_ready,
    input  bus_pkg::mem_rsp_t  clint_rsp,
    // Request payload shared by both targets
    output bus_pkg::mem_req_t  fwd_req
);
    import bus_pkg::*;

    logic hit_clint;
    logic pending;
    logic to_clint;

    // Address decode against the timer window
    assign hit_clint = (req.addr - addr_t'(`CLINT_BASE)) < addr_t'(`CLINT_SIZE);

    ////////////////////
    // Request steering
    assign fwd_req         = req;
    assign axi_req_valid   = req_valid && !pending && !hit_clint;
    assign clint_req_valid = req_valid && !pending && hit_clint;
    assign req_ready       = !pending && (hit_clint ? clint_req_ready : axi_req_ready);

    ////////////////////
    // Only the marked target talks back
    assign rsp_valid       = pending && (to_clint ? clint_rsp_valid : axi_rsp_valid);
    assign rsp             = to_clint ? clint_rsp : axi_rsp;
    assign axi_rsp_ready   = pending && !to_clint && rsp_ready;
    assign clint_rsp_ready = pending && to_clint && rsp_ready;

    // Pending and target marks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            to_clint <= 1'b0;
        end else begin
            if (req_valid && req_ready) begin
                pending  <= 1'b1;
                to_clint <= hit_clint;
            end else if (rsp_valid && rsp_ready) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

//--- source/axi_lite_bridge.sv
////////////////////
// AXI4-Lite master bridge
// Turns one core request into AR/R or AW+W/B traffic
// and holds the response until the core takes it
////////////////////
`timescale 1ns/1ps

module axi_lite_bridge (
    input  logic               clk,
    input  logic               rst_n,
    // Core side
    input  logic               req_valid,
    output logic               req_ready,
    input  bus_pkg::mem_req_t  req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output bus_pkg::mem_rsp_t  rsp,
    // AXI side
    output bus_pkg::axi_m2s_t  axi_out,
    input  bus_pkg::axi_s2m_t  axi_in
);
    import bus_pkg::*;

    bridge_state_t state;
    mem_req_t      req_q;
    mem_rsp_t      rsp_q;
    logic          aw_done;
    logic          w_done;
    logic          ar_hs;
    logic          r_hs;
    logic          aw_hs;
    logic          w_hs;
    logic          b_hs;

    // New work only once the last response has left
    assign req_ready = (state == IDLE) && !rsp_valid;
    assign rsp       = rsp_q;

    ////////////////////
    // Channel drive
    always_comb begin
        axi_out.arvalid = (state == READ_ADDR);
        axi_out.araddr  = req_q.addr;
        axi_out.rready  = (state == READ_DATA);
        axi_out.awvalid = (state == WRITE_REQ) && !aw_done;
        axi_out.awaddr  = req_q.addr;
        axi_out.wvalid  = (state == WRITE_REQ) && !w_done;
        axi_out.wdata   = req_q.wdata;
        axi_out.wstrb   = req_q.wstrb;
        axi_out.bready  = (state == WRITE_RESP);
    end

    assign ar_hs = axi_out.arvalid && axi_in.arready;
    assign r_hs  = axi_out.rready && axi_in.rvalid;
    assign aw_hs = axi_out.awvalid && axi_in.awready;
    assign w_hs  = axi_out.wvalid && axi_in.wready;
    assign b_hs  = axi_out.bready && axi_in.bvalid;

    ////////////////////
    // Bridge FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (req_valid && req_ready) begin
                        state   <= req.write ? WRITE_REQ : READ_ADDR;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                READ_ADDR: begin
                    if (ar_hs) begin
                        state <= READ_DATA;
                    end
                end
                READ_DATA: begin
                    if (r_hs) begin
                        state     <= IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                WRITE_REQ: begin
                    // AW and W may finish in either order
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done <= 1'b1;
                    end
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (b_hs) begin
                        state     <= IDLE;
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (r_hs) begin
            rsp_q.rdata <= axi_in.rdata;
            rsp_q.error <= (axi_in.rresp != AXI_RESP_OKAY);
        end else if (b_hs) begin
            rsp_q.rdata <= '0;
            rsp_q.error <= (axi_in.bresp != AXI_RESP_OKAY);
        end
    end

endmodule

//--- source/clint_lite.sv
////////////////////
// Machine timer and software interrupt block
// msip and mtimecmp registers, compare against mtime
////////////////////
`timescale 1ns/1ps
`include "bus_config.svh"

module clint_lite (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  bus_pkg::mem_req_t   req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output bus_pkg::mem_rsp_t   rsp,
    input  bus_pkg::mtime_t     mtime,
    input  logic                ext_irq,
    output bus_pkg::interrupt_t irq
);
    import bus_pkg::*;

    localparam int OFS_W = $clog2(`CLINT_SIZE);

    logic             msip;
    mtime_t           mtimecmp;
    logic [OFS_W-1:0] ofs;
    data_t            rd_data;
    logic             rd_err;
    logic             accept;

    // Byte-wise merge of a write into a register word
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_ready = !rsp_valid;
    assign accept    = req_valid && req_ready;
    assign ofs       = req.addr[OFS_W-1:0];

    ////////////////////
    // Register read decode
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (ofs)
            `CLINT_MSIP_OFS:        rd_data = {{($bits(data_t)-1){1'b0}}, msip};
            `CLINT_MTIMECMP_LO_OFS: rd_data = mtimecmp[31:0];
            `CLINT_MTIMECMP_HI_OFS: rd_data = mtimecmp[63:32];
            default:                rd_err  = 1'b1;
        endcase
    end

    // Registers, response and interrupt outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip      <= 1'b0;
            mtimecmp  <= '1;
            rsp_valid <= 1'b0;
            rsp       <= '0;
            irq       <= '0;
        end else begin
            if (accept && req.write) begin
                case (ofs)
                    `CLINT_MSIP_OFS: begin
                        if (req.wstrb[0]) begin
                            msip <= req.wdata[0];
                        end
                    end
                    `CLINT_MTIMECMP_LO_OFS:
                        mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], req.wdata, req.wstrb);
                    `CLINT_MTIMECMP_HI_OFS:
                        mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], req.wdata, req.wstrb);
                    default: ;
                endcase
            end
            if (accept) begin
                rsp_valid <= 1'b1;
                rsp.rdata <= rd_data;
                rsp.error <= rd_err;
            end else if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            irq.software <= msip;
            irq.timer    <= (mtime >= mtimecmp);
            irq.external <= ext_irq;
        end
    end

endmodule

//--- source/core_bus_top.sv
////////////////////
// Core data bus wrapper
// Router, AXI4-Lite bridge and timer block,
// with the AXI structs flattened to m_axi_ ports
////////////////////
`timescale 1ns/1ps

module core_bus_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // Core request and response
    input  logic                   req_valid,
    output logic                   req_ready,
    input  bus_pkg::mem_req_t      req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output bus_pkg::mem_rsp_t      rsp,
    // AR
    output logic                   m_axi_arvalid,
    input  logic                   m_axi_arready,
    output bus_pkg::addr_t         m_axi_araddr,
    // R
    input  logic                   m_axi_rvalid,
    output logic                   m_axi_rready,
    input  bus_pkg::data_t         m_axi_rdata,
    input  bus_pkg::axi_resp_t     m_axi_rresp,
    // AW
    output logic                   m_axi_awvalid,
    input  logic                   m_axi_awready,
    output bus_pkg::addr_t         m_axi_awaddr,
    // W
    output logic                   m_axi_wvalid,
    input  logic                   m_axi_wready,
    output bus_pkg::data_t         m_axi_wdata,
    output bus_pkg::strb_t         m_axi_wstrb,
    // B
    input  logic                   m_axi_bvalid,
    output logic                   m_axi_bready,
    input  bus_pkg::axi_resp_t     m_axi_bresp,
    // Timer and interrupts
    input  bus_pkg::mtime_t        mtime,
    input  logic                   ext_irq,
    output bus_pkg::interrupt_t    irq
);
    import bus_pkg::*;

    logic     axi_req_valid;
    logic     axi_req_ready;
    logic     axi_rsp_valid;
    logic     axi_rsp_ready;
    mem_rsp_t axi_rsp;
    logic     clint_req_valid;
    logic     clint_req_ready;
    logic     clint_rsp_valid;
    logic     clint_rsp_ready;
    mem_rsp_t clint_rsp;
    mem_req_t fwd_req;
    axi_m2s_t axi_out;
    axi_s2m_t axi_in;

    req_router req_router_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req             (req),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .rsp             (rsp),
        .axi_req_valid   (axi_req_valid),
        .axi_req_ready   (axi_req_ready),
        .axi_rsp_valid   (axi_rsp_valid),
        .axi_rsp_ready   (axi_rsp_ready),
        .axi_rsp         (axi_rsp),
        .clint_req_valid (clint_req_valid),
        .clint_req_ready (clint_req_ready),
        .clint_rsp_valid (clint_rsp_valid),
        .clint_rsp_ready (clint_rsp_ready),
        .clint_rsp       (clint_rsp),
        .fwd_req         (fwd_req)
    );

    axi_lite_bridge axi_lite_bridge_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (axi_req_valid),
        .req_ready (axi_req_ready),
        .req       (fwd_req),
        .rsp_valid (axi_rsp_valid),
        .rsp_ready (axi_rsp_ready),
        .rsp       (axi_rsp),
        .axi_out   (axi_out),
        .axi_in    (axi_in)
    );

    clint_lite clint_lite_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (clint_req_valid),
        .req_ready (clint_req_ready),
        .req       (fwd_req),
        .rsp_valid (clint_rsp_valid),
        .rsp_ready (clint_rsp_ready),
        .rsp       (clint_rsp),
        .mtime     (mtime),
        .ext_irq   (ext_irq),
        .irq       (irq)
    );

    ////////////////////
    // Master to slave fields
    assign m_axi_arvalid = axi_out.arvalid;
    assign m_axi_araddr  = axi_out.araddr;
    assign m_axi_rready  = axi_out.rready;
    assign m_axi_awvalid = axi_out.awvalid;
    assign m_axi_awaddr  = axi_out.awaddr;
    assign m_axi_wvalid  = axi_out.wvalid;
    assign m_axi_wdata   = axi_out.wdata;
    assign m_axi_wstrb   = axi_out.wstrb;
    assign m_axi_bready  = axi_out.bready;

    ////////////////////
    // Slave to master fields
    assign axi_in.arready = m_axi_arready;
    assign axi_in.rvalid  = m_axi_rvalid;
    assign axi_in.rdata   = m_axi_rdata;
    assign axi_in.rresp   = m_axi_rresp;
    assign axi_in.awready = m_axi_awready;
    assign axi_in.wready  = m_axi_wready;
    assign axi_in.bvalid  = m_axi_bvalid;
    assign axi_in.bresp   = m_axi_bresp;

endmodule

//--- test/axi_mem_model.sv
////////////////////
// AXI4-Lite slave memory for the testbench
// Random ready stalls, SLVERR at and above an error base
////////////////////
`timescale 1ns/1ps

module axi_mem_model #(
    parameter bus_pkg::addr_t ERR_BASE = 32'hF000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               arvalid,
    output logic               arready,
    input  bus_pkg::addr_t     araddr,
    output logic               rvalid,
    input  logic               rready,
    output bus_pkg::data_t     rdata,
    output bus_pkg::axi_resp_t rresp,
    input  logic               awvalid,
    output logic               awready,
    input  bus_pkg::addr_t     awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  bus_pkg::data_t     wdata,
    input  bus_pkg::strb_t     wstrb,
    output logic               bvalid,
    input  logic               bready,
    output bus_pkg::axi_resp_t bresp
);
    import bus_pkg::*;

    localparam int        MEM_WORDS = 4096;
    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam axi_resp_t SLVERR    = 2'b10;

    data_t  mem [0:MEM_WORDS-1];
    integer seed;
    logic   aw_got;
    logic   w_got;
    addr_t  aw_addr_q;
    data_t  w_data_q;
    strb_t  w_strb_q;

    // Byte lanes with a strobe take the new data
    function automatic data_t merge_strobes(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(strb_t); i++) begin
            if (strb[i]) begin
                merged[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Each word starts as its byte address XOR a fixed pattern
    initial begin
        seed = 32'h44d6;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5A5A_0000 ^ (i * 4);
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= RESP_OKAY;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            // Random stalls on every ready
            arready <= !rvalid && !(arvalid && arready) && (($random(seed) % 3) != 0);
            awready <= !aw_got && !(awvalid && awready) && !bvalid
                       && (($random(seed) % 3) != 0);
            wready  <= !w_got && !(wvalid && wready) && !bvalid
                       && (($random(seed) % 3) != 0);

            ////////////////////
            // Read channel
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                if (araddr >= ERR_BASE) begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end else begin
                    rdata <= mem[araddr[13:2]];
                    rresp <= RESP_OKAY;
                end
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            ////////////////////
            // Write channels
            if (awvalid && awready) begin
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            if (aw_got && w_got && !bvalid) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                if (aw_addr_q >= ERR_BASE) begin
                    bresp <= SLVERR;
                end else begin
                    bresp <= RESP_OKAY;
                    mem[aw_addr_q[13:2]] <= merge_strobes(mem[aw_addr_q[13:2]],
                                                          w_data_q, w_strb_q);
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- test/tb_core_bus_top.sv
////////////////////
// Testbench for the core data bus wrapper
// Table of core requests with expected responses and interrupts,
// random response back-pressure and AXI slave stalls
////////////////////
`timescale 1ns/1ps
`include "bus_config.svh"

module tb_core_bus_top;
    import bus_pkg::*;

    localparam int    REQ_TIMEOUT   = 50;
    localparam int    RSP_TIMEOUT   = 200;
    localparam addr_t ERR_BASE      = 32'hF000_0000;
    localparam addr_t MSIP_ADDR     = `CLINT_BASE + 32'h0;
    localparam addr_t UNMAPPED_ADDR = `CLINT_BASE + 32'h4;
    localparam addr_t MTCMP_LO_ADDR = `CLINT_BASE + 32'h8;
    localparam addr_t MTCMP_HI_ADDR = `CLINT_BASE + 32'hC;
    localparam addr_t UNMAPPED_WR   = `CLINT_BASE + 32'h10;

    // One table entry
    typedef struct packed {
        logic       write;
        addr_t      addr;
        data_t      wdata;
        strb_t      wstrb;
        data_t      exp_rdata;
        logic       exp_error;
        mtime_t     mtime;
        logic       ext_irq;
        interrupt_t exp_irq;
    } test_vec_t;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    mem_req_t   req;
    logic       rsp_valid;
    logic       rsp_ready;
    mem_rsp_t   rsp;
    logic       m_axi_arvalid;
    logic       m_axi_arready;
    addr_t      m_axi_araddr;
    logic       m_axi_rvalid;
    logic       m_axi_rready;
    data_t      m_axi_rdata;
    axi_resp_t  m_axi_rresp;
    logic       m_axi_awvalid;
    logic       m_axi_awready;
    addr_t      m_axi_awaddr;
    logic       m_axi_wvalid;
    logic       m_axi_wready;
    data_t      m_axi_wdata;
    strb_t      m_axi_wstrb;
    logic       m_axi_bvalid;
    logic       m_axi_bready;
    axi_resp_t  m_axi_bresp;
    mtime_t     mtime;
    logic       ext_irq;
    interrupt_t irq;

    test_vec_t  tests[$];
    string      names[$];
    integer     seed;
    int         errors;
    int         checks;
    bit         timed_out;
    logic [9:0] reset_state;

    core_bus_top core_bus_top_inst (.*);

    axi_mem_model #(.ERR_BASE(ERR_BASE)) axi_mem_model_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (m_axi_arvalid),
        .arready (m_axi_arready),
        .araddr  (m_axi_araddr),
        .rvalid  (m_axi_rvalid),
        .rready  (m_axi_rready),
        .rdata   (m_axi_rdata),
        .rresp   (m_axi_rresp),
        .awvalid (m_axi_awvalid),
        .awready (m_axi_awready),
        .awaddr  (m_axi_awaddr),
        .wvalid  (m_axi_wvalid),
        .wready  (m_axi_wready),
        .wdata   (m_axi_wdata),
        .wstrb   (m_axi_wstrb),
        .bvalid  (m_axi_bvalid),
        .bready  (m_axi_bready),
        .bresp   (m_axi_bresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_test(input string name, input logic write, input addr_t addr,
                            input data_t wdata, input strb_t wstrb, input data_t exp_rdata,
                            input logic exp_error, input mtime_t mt, input logic ext,
                            input interrupt_t exp_irq);
        test_vec_t t;
        t.write     = write;
        t.addr      = addr;
        t.wdata     = wdata;
        t.wstrb     = wstrb;
        t.exp_rdata = exp_rdata;
        t.exp_error = exp_error;
        t.mtime     = mt;
        t.ext_irq   = ext;
        t.exp_irq   = exp_irq;
        tests.push_back(t);
        names.push_back(name);
    endtask

    ////////////////////
    // Stimulus table
    task automatic build_table();
        // AXI path with a full word then a partial strobe merge
        add_test("axi_wr_word", 1'b1, 32'h0000_1000, 32'hDEAD_BEEF, 4'hF, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("axi_rd_word", 1'b0, 32'h0000_1000, 32'h0, 4'h0, 32'hDEAD_BEEF,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("axi_wr_partial", 1'b1, 32'h0000_1000, 32'h1122_3344, 4'b0101, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("axi_rd_merged", 1'b0, 32'h0000_1000, 32'h0, 4'h0, 32'hDE22_BE44,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("axi_wr_slverr", 1'b1, 32'hF000_0010, 32'hCAFE_F00D, 4'hF, 32'h0,
                 1'b1, 64'h0, 1'b0, 3'b000);
        add_test("axi_rd_slverr", 1'b0, 32'hF000_0010, 32'h0, 4'h0, 32'h0,
                 1'b1, 64'h0, 1'b0, 3'b000);
        // Timer compare registers
        add_test("cmp_lo_wr", 1'b1, MTCMP_LO_ADDR, 32'h0000_0100, 4'hF, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("cmp_hi_wr", 1'b1, MTCMP_HI_ADDR, 32'h0000_0000, 4'hF, 32'h0,
                 1'b0, 64'h50, 1'b0, 3'b000);
        add_test("cmp_lo_rd", 1'b0, MTCMP_LO_ADDR, 32'h0, 4'h0, 32'h0000_0100,
                 1'b0, 64'h50, 1'b0, 3'b000);
        add_test("cmp_hi_rd", 1'b0, MTCMP_HI_ADDR, 32'h0, 4'h0, 32'h0,
                 1'b0, 64'h50, 1'b0, 3'b000);
        add_test("clint_rd_unmapped", 1'b0, UNMAPPED_ADDR, 32'h0, 4'h0, 32'h0,
                 1'b1, 64'hFF, 1'b0, 3'b000);
        add_test("clint_wr_unmapped", 1'b1, UNMAPPED_WR, 32'hFFFF_FFFF, 4'hF, 32'h0,
                 1'b1, 64'hFF, 1'b0, 3'b000);
        add_test("timer_fire", 1'b0, MTCMP_LO_ADDR, 32'h0, 4'h0, 32'h0000_0100,
                 1'b0, 64'h100, 1'b0, 3'b010);
        // Software and external interrupts
        add_test("msip_set", 1'b1, MSIP_ADDR, 32'h1, 4'hF, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b100);
        add_test("msip_rd", 1'b0, MSIP_ADDR, 32'h0, 4'h0, 32'h1,
                 1'b0, 64'h0, 1'b0, 3'b100);
        add_test("msip_clr", 1'b1, MSIP_ADDR, 32'h0, 4'hF, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("ext_irq_set", 1'b0, MSIP_ADDR, 32'h0, 4'h0, 32'h0,
                 1'b0, 64'h0, 1'b1, 3'b001);
        add_test("axi_wr_word2", 1'b1, 32'h0000_2004, 32'h1234_5678, 4'hF, 32'h0,
                 1'b0, 64'h0, 1'b0, 3'b000);
        add_test("axi_rd_word2", 1'b0, 32'h0000_2004, 32'h0, 4'h0, 32'h1234_5678,
                 1'b0, 64'h0, 1'b0, 3'b000);
    endtask

    // Apply one entry and check its response and the interrupt outputs
    task automatic run_test(input int idx);
        test_vec_t t;
        mem_rsp_t  held;
        bit        seen;
        bit        done;
        int        wait_cnt;
        t         = tests[idx];
        mtime     <= t.mtime;
        ext_irq   <= t.ext_irq;
        req_valid <= 1'b1;
        req.addr  <= t.addr;
        req.wdata <= t.wdata;
        req.wstrb <= t.wstrb;
        req.write <= t.write;

        wait_cnt = 0;
        @(posedge clk);
        while (!req_ready && wait_cnt < REQ_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!req_ready) begin
            $display("Timeout: request %s was never accepted", names[idx]);
            timed_out = 1'b1;
            errors++;
            return;
        end
        req_valid <= 1'b0;

        // Response wait under random back-pressure
        seen     = 1'b0;
        done     = 1'b0;
        wait_cnt = 0;
        while (!done && wait_cnt < RSP_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
            if (rsp_valid) begin
                if (seen) begin
                    checks++;
                    if (rsp !== held) begin
                        errors++;
                        $display("Response to %s changed while it was held", names[idx]);
                    end
                end
                checks++;
                if (req_ready) begin
                    errors++;
                    $display("Request port open while the response to %s is held",
                             names[idx]);
                end
                held = rsp;
                seen = 1'b1;
                done = rsp_ready;
            end
            rsp_ready <= ($random(seed) % 3) != 0;
        end
        if (!done) begin
            $display("Timeout: no response to %s", names[idx]);
            timed_out = 1'b1;
            errors++;
            return;
        end

        checks++;
        if (!t.write && held.rdata !== t.exp_rdata) begin
            errors++;
            $display("FAILED %s: rdata expected %h, actual %h",
                     names[idx], t.exp_rdata, held.rdata);
        end
        checks++;
        if (held.error !== t.exp_error) begin
            errors++;
            $display("FAILED %s: error expected %b, actual %b",
                     names[idx], t.exp_error, held.error);
        end
        // One idle cycle, then the registered interrupt bits
        @(posedge clk);
        checks++;
        if (irq !== t.exp_irq) begin
            errors++;
            $display("FAILED %s: irq expected %b, actual %b", names[idx], t.exp_irq, irq);
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        seed      = 32'h44d6;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        mtime     = '0;
        ext_irq   = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // Handshake and interrupt outputs right after reset
        reset_state = {req_ready, rsp_valid, m_axi_arvalid, m_axi_rready,
                       m_axi_awvalid, m_axi_wvalid, m_axi_bready, irq};
        checks++;
        if (reset_state !== 10'b10_0000_0000) begin
            errors++;
            $display("FAILED reset_state: expected %b, actual %b",
                     10'b10_0000_0000, reset_state);
        end
        for (int i = 0; i < tests.size() && !timed_out; i++) begin
            run_test(i);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/bus_pkg.sv
source/req_router.sv
source/axi_lite_bridge.sv
source/clint_lite.sv
source/core_bus_top.sv
test/axi_mem_model.sv
test/tb_core_bus_top.sv

//--- Makefile
# Verilator build and run for the core data bus testbench

VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_core_bus_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
